//--- tcdm_subsys.f
design/tcdm_pkg.sv
design/tcdm_arbiter.sv
design/tcdm_port_mux.sv
design/tcdm_r_user_filter.sv
design/tcdm_bank.sv
design/tcdm_subsys.sv
tb/tcdm_subsys_tb.sv

//--- Bender.yml
package:
  name: tcdm_subsys

sources:
  # package first, then the leaf modules, then the top level
  - files:
      - design/tcdm_pkg.sv
      - design/tcdm_arbiter.sv
      - design/tcdm_port_mux.sv
      - design/tcdm_r_user_filter.sv
      - design/tcdm_bank.sv
      - design/tcdm_subsys.sv

  # testbench, only for simulation
  - target: test
    files:
      - tb/tcdm_subsys_tb.sv

//--- tb/tcdm_subsys_tb.sv
// testbench with clock, reset, stimulus, reference model and checks of the memory subsystem
`default_nettype none

module tcdm_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod    = 4;   // ns
  localparam int PreloadWords = 16;  // addresses written in full before any read
  // cycle budgets of the tests in run order
  localparam int LenReset     = 8;
  localparam int LenWriteRead = 30;
  localparam int LenContend   = 30;
  localparam int LenRouting   = 70;
  localparam int LenBurst     = 16;
  localparam int LenTag       = 16;
  localparam int LenSum = LenReset + LenWriteRead + LenContend + LenRouting + LenBurst + LenTag;

  logic            clk_i;
  logic            rst_ni;
  logic            clear_i;
  logic            tag_en_i;
  logic            init_req     [tcdm_pkg::NumInit];
  tcdm_pkg::addr_t init_add     [tcdm_pkg::NumInit];
  logic            init_wen     [tcdm_pkg::NumInit];
  tcdm_pkg::be_t   init_be      [tcdm_pkg::NumInit];
  tcdm_pkg::data_t init_data    [tcdm_pkg::NumInit];
  logic            init_gnt     [tcdm_pkg::NumInit];
  logic            init_r_valid [tcdm_pkg::NumInit];
  tcdm_pkg::data_t init_r_data  [tcdm_pkg::NumInit];

  // reference model state
  tcdm_pkg::data_t              ref_mem [tcdm_pkg::NumWords]; // expected bank contents
  logic                         prio_q;     // 1 when initiator 1 wins the next contest
  tcdm_pkg::init_id_t           tag_q;      // expected held tag
  logic                         exp_rd_q;   // a read was accepted last cycle
  tcdm_pkg::data_t              exp_data_q; // its expected data
  logic                         rst_q;      // low during reset and one cycle after
  logic [tcdm_pkg::NumInit-1:0] gnt_vec, rv_vec, acc_vec;
  logic [tcdm_pkg::NumInit-1:0] exp_gnt, exp_rv;
  tcdm_pkg::data_t              got_data;   // response data at the expected port

  int errors;
  int err_at_start;
  int tests_run;
  int tests_failed;
  int n_resp;                               // read responses checked

  tcdm_subsys dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .tag_en_i     (tag_en_i),
    .init_req     (init_req),
    .init_add     (init_add),
    .init_wen     (init_wen),
    .init_be      (init_be),
    .init_data    (init_data),
    .init_gnt     (init_gnt),
    .init_r_valid (init_r_valid),
    .init_r_data  (init_r_data)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // packed views of the port arrays
  always_comb begin
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      gnt_vec[i] = init_gnt[i];
      rv_vec[i]  = init_r_valid[i];
      acc_vec[i] = init_req[i] && init_gnt[i]; // accepted this cycle
    end
  end

  // expected grant goes to the lone requester or else to the favoured one
  always_comb begin
    exp_gnt = '0;
    if (init_req[0] && init_req[1]) begin
      exp_gnt[prio_q] = 1'b1;
    end else if (init_req[0]) begin
      exp_gnt[0] = 1'b1;
    end else if (init_req[1]) begin
      exp_gnt[1] = 1'b1;
    end
  end

  // expected response routing follows the held tag
  always_comb begin
    exp_rv = '0;
    if (exp_rd_q) begin
      exp_rv[tag_q] = 1'b1;
    end
    got_data = init_r_data[tag_q];
  end

  // memory, priority and tag models updated on accepted requests
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q   <= 1'b0;
      tag_q    <= '0;
      exp_rd_q <= 1'b0;
      rst_q    <= 1'b0;
    end else begin
      rst_q    <= 1'b1;
      exp_rd_q <= 1'b0;
      for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
        if (acc_vec[i]) begin
          if (init_wen[i]) begin
            exp_rd_q   <= 1'b1;                    // answered next cycle
            exp_data_q <= ref_mem[init_add[i]];
          end else begin
            for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
              if (init_be[i][b]) begin
                ref_mem[init_add[i]][b*8 +: 8] <= init_data[i][b*8 +: 8]; // enabled lanes
              end
            end
          end
          prio_q <= (i == 0) ? 1'b1 : 1'b0;        // the other one is favoured next
          if (tag_en_i) begin
            tag_q <= tcdm_pkg::init_id_t'(i);
          end
        end
      end
      if (clear_i) begin
        tag_q <= '0;                               // clear beats capture
      end
      if (exp_rd_q) begin
        n_resp <= n_resp + 1;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("** Error at %0.1f ns: %s expected %h got %h", $realtime, name, exp, got);
    errors++;
  endtask

  // quiet outputs during reset and in the first cycle after it
  a_reset_quiet: assert property (
    @(posedge clk_i) !rst_q |-> ({gnt_vec, rv_vec} == '0)
  ) else report_mismatch("init_gnt,init_r_valid", '0, $sampled({gnt_vec, rv_vec}));

  a_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni) gnt_vec == exp_gnt
  ) else report_mismatch("init_gnt", $sampled(exp_gnt), $sampled(gnt_vec));

  a_r_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rv_vec == exp_rv
  ) else report_mismatch("init_r_valid", $sampled(exp_rv), $sampled(rv_vec));

  a_r_data: assert property (
    @(posedge clk_i) disable iff (!rst_ni) exp_rd_q |-> (got_data == exp_data_q)
  ) else report_mismatch("init_r_data", $sampled(exp_data_q), $sampled(got_data));

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #0.5;                                        // drive point
    end
  endtask

  task automatic set_request(input int i, input logic rd, input tcdm_pkg::addr_t a,
                             input tcdm_pkg::be_t b, input tcdm_pkg::data_t d);
    init_req[i]  = 1'b1;
    init_wen[i]  = rd;                             // high means read
    init_add[i]  = a;
    init_be[i]   = b;
    init_data[i] = d;
  endtask

  task automatic random_request(input int i, input int read_pct);
    set_request(i, ($urandom_range(99) < read_pct),
                tcdm_pkg::addr_t'($urandom_range(PreloadWords - 1)),
                tcdm_pkg::be_t'($urandom_range(15, 1)), $urandom);
  endtask

  // hold the request until granted and drop it at the drive point after the grant edge
  task automatic wait_grant(input int i);
    logic granted;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk_i);
      granted = init_gnt[i];                       // stable mid-cycle
      @(posedge clk_i);
      #0.5;
    end
    init_req[i] = 1'b0;
  endtask

  // both initiators keep requesting and a granted one moves on to a new request
  task automatic contend(input int cycles);
    logic g [tcdm_pkg::NumInit];
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      random_request(i, 50);
    end
    repeat (cycles) begin
      @(negedge clk_i);
      for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
        g[i] = init_gnt[i];
      end
      @(posedge clk_i);
      #0.5;
      for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
        if (g[i]) begin
          random_request(i, 50);
        end
      end
    end
    init_req[0] = 1'b0;
    init_req[1] = 1'b0;
  endtask

  task automatic end_test(input string name);
    idle_cycles(2);                                // let the last response be checked
    tests_run++;
    if (errors != err_at_start) begin
      tests_failed++;
    end
    $display("test %-18s %s (%0d errors)", name, (errors == err_at_start) ? "ok" : "failed",
             errors - err_at_start);
    err_at_start = errors;
  endtask

  // watchdog
  initial begin
    #(LenSum * 4 * ClkPeriod);
    $display("watchdog expired after %0d ns, a test did not finish", LenSum * 4 * ClkPeriod);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int k;
    tcdm_pkg::addr_t a;
    void'($urandom(32'ha4c));                      // single seed for the run
    errors = 0;
    err_at_start = 0;
    tests_run = 0;
    tests_failed = 0;
    n_resp = 0;
    clk_i = 1'b0;
    rst_ni = 1'b1;
    clear_i = 1'b0;
    tag_en_i = 1'b1;
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      set_request(i, 1'b0, '0, '0, '0);
      init_req[i] = 1'b0;
    end
    #1 rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #0.5 rst_ni = 1'b1;
    end_test("reset state");

    for (int w = 0; w < PreloadWords; w++) begin
      set_request(0, 1'b0, tcdm_pkg::addr_t'(w), 4'hf, $urandom); // full words first
      wait_grant(0);
    end
    a = tcdm_pkg::addr_t'($urandom_range(PreloadWords - 1));
    set_request(1, 1'b0, a, tcdm_pkg::be_t'($urandom_range(14, 1)), $urandom); // partial
    wait_grant(1);
    set_request(1, 1'b1, a, '0, '0);
    wait_grant(1);
    idle_cycles(1);
    set_request(0, 1'b1, a, '0, '0);
    wait_grant(0);
    end_test("write then read");

    contend(24);
    end_test("contention");

    repeat (16) begin
      k = $urandom_range(1);
      random_request(k, 75);
      wait_grant(k);
      idle_cycles($urandom_range(2));
    end
    end_test("response routing");

    for (int r = 0; r < 8; r++) begin
      set_request(r / 6, 1'b1, tcdm_pkg::addr_t'($urandom_range(PreloadWords - 1)), '0, '0);
      wait_grant(r / 6);                           // consecutive grants with the last two from 1
    end
    end_test("back-to-back reads");

    set_request(1, 1'b1, 8'd3, '0, '0);
    wait_grant(1);                                 // held tag becomes 1
    tag_en_i = 1'b0;
    set_request(0, 1'b1, 8'd4, '0, '0);
    wait_grant(0);                                 // answered on initiator 1
    idle_cycles(1);
    clear_i = 1'b1;
    idle_cycles(1);
    clear_i = 1'b0;
    set_request(1, 1'b1, 8'd5, '0, '0);
    wait_grant(1);                                 // answered on initiator 0
    idle_cycles(1);
    tag_en_i = 1'b1;
    end_test("tag disable, clear");

    $display("tests run %0d, failed %0d, errors %0d, read responses checked %0d",
             tests_run, tests_failed, errors, n_resp);
    if (errors == 0 && n_resp > 0) begin
      $display("PASS: all tests");
    end else begin
      if (n_resp == 0) begin
        $display("no read response reached the checks");
      end
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/tcdm_subsys.sv
// top-level module of the shared-memory subsystem with arbiter, multiplexer, filter and bank
`default_nettype none

module tcdm_subsys (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,                           // clear of the held tag
  input  logic            tag_en_i,                          // tag capture enable
  // per-initiator request ports
  input  logic            init_req     [tcdm_pkg::NumInit],
  input  tcdm_pkg::addr_t init_add     [tcdm_pkg::NumInit],
  input  logic            init_wen     [tcdm_pkg::NumInit],  // high means read
  input  tcdm_pkg::be_t   init_be      [tcdm_pkg::NumInit],
  input  tcdm_pkg::data_t init_data    [tcdm_pkg::NumInit],
  output logic            init_gnt     [tcdm_pkg::NumInit],
  // per-initiator response ports
  output logic            init_r_valid [tcdm_pkg::NumInit],
  output tcdm_pkg::data_t init_r_data  [tcdm_pkg::NumInit]
);

  tcdm_pkg::init_id_t sel;          // current winner

  // multiplexer to filter
  logic               tgt_req;
  tcdm_pkg::addr_t    tgt_add;
  logic               tgt_wen;
  tcdm_pkg::be_t      tgt_be;
  tcdm_pkg::data_t    tgt_data;
  tcdm_pkg::init_id_t tgt_user;
  logic               tgt_gnt;
  logic               tgt_r_valid;
  tcdm_pkg::data_t    tgt_r_data;
  tcdm_pkg::init_id_t tgt_r_user;

  // filter to bank
  logic               mem_req;
  tcdm_pkg::addr_t    mem_add;
  logic               mem_wen;
  tcdm_pkg::be_t      mem_be;
  tcdm_pkg::data_t    mem_data;
  logic               mem_gnt;
  logic               mem_r_valid;
  tcdm_pkg::data_t    mem_r_data;

  tcdm_arbiter i_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req     (init_req),
    .tgt_gnt (tgt_gnt),
    .gnt     (init_gnt),
    .sel     (sel)
  );

  tcdm_port_mux i_port_mux (
    .sel         (sel),
    .req         (init_req),
    .add         (init_add),
    .wen         (init_wen),
    .be          (init_be),
    .data        (init_data),
    .r_valid     (init_r_valid),
    .r_data      (init_r_data),
    .tgt_req     (tgt_req),
    .tgt_add     (tgt_add),
    .tgt_wen     (tgt_wen),
    .tgt_be      (tgt_be),
    .tgt_data    (tgt_data),
    .tgt_user    (tgt_user),
    .tgt_r_valid (tgt_r_valid),
    .tgt_r_data  (tgt_r_data),
    .tgt_r_user  (tgt_r_user)
  );

  tcdm_r_user_filter i_r_user_filter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .enable_i    (tag_en_i),
    .tgt_req     (tgt_req),
    .tgt_add     (tgt_add),
    .tgt_wen     (tgt_wen),
    .tgt_be      (tgt_be),
    .tgt_data    (tgt_data),
    .tgt_user    (tgt_user),
    .tgt_gnt     (tgt_gnt),
    .tgt_r_valid (tgt_r_valid),
    .tgt_r_data  (tgt_r_data),
    .tgt_r_user  (tgt_r_user),
    .mem_req     (mem_req),
    .mem_add     (mem_add),
    .mem_wen     (mem_wen),
    .mem_be      (mem_be),
    .mem_data    (mem_data),
    .mem_gnt     (mem_gnt),
    .mem_r_valid (mem_r_valid),
    .mem_r_data  (mem_r_data)
  );

  tcdm_bank i_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req     (mem_req),
    .add     (mem_add),
    .wen     (mem_wen),
    .be      (mem_be),
    .data    (mem_data),
    .gnt     (mem_gnt),
    .r_valid (mem_r_valid),
    .r_data  (mem_r_data)
  );

endmodule

`default_nettype wire

//--- design/tcdm_bank.sv
// single-ported memory bank module with byte-enabled writes and one-cycle read latency
`default_nettype none

module tcdm_bank (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req,      // access strobe
  input  tcdm_pkg::addr_t add,      // word address
  input  logic            wen,      // high means read, low means write
  input  tcdm_pkg::be_t   be,       // byte lanes written
  input  tcdm_pkg::data_t data,     // write data
  output logic            gnt,      // always granted
  output logic            r_valid,  // read response strobe
  output tcdm_pkg::data_t r_data    // read response data
);

  tcdm_pkg::data_t mem_q [tcdm_pkg::NumWords]; // storage array
  tcdm_pkg::data_t r_data_q;                   // registered read word
  logic            r_valid_q;
  logic            rd_en;                      // granted read this cycle
  logic            wr_en;                      // granted write this cycle

  assign gnt   = req;              // single port so no contention here
  assign rd_en = req && wen;
  assign wr_en = req && !wen;

  // storage and registered read data
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (be[b]) begin
          mem_q[add][b*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth] <=
            data[b*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth]; // merge enabled lanes only
        end
      end
    end
    if (rd_en) begin
      r_data_q <= mem_q[add];      // data lands with r_valid next cycle
    end
  end

  // response valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_en;          // one pulse per granted read
    end
  end

  assign r_valid = r_valid_q;
  assign r_data  = r_data_q;

endmodule

`default_nettype wire

//--- design/tcdm_r_user_filter.sv
// response-user filter module holding the request tag at the one-cycle boundary, with checks
`default_nettype none

module tcdm_r_user_filter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,      // drops the held tag back to 0
  input  logic               enable_i,     // tag capture enable
  // target side, toward the multiplexer
  input  logic               tgt_req,
  input  tcdm_pkg::addr_t    tgt_add,
  input  logic               tgt_wen,
  input  tcdm_pkg::be_t      tgt_be,
  input  tcdm_pkg::data_t    tgt_data,
  input  tcdm_pkg::init_id_t tgt_user,
  output logic               tgt_gnt,
  output logic               tgt_r_valid,
  output tcdm_pkg::data_t    tgt_r_data,
  output tcdm_pkg::init_id_t tgt_r_user,
  // initiator side, toward the bank
  output logic               mem_req,
  output tcdm_pkg::addr_t    mem_add,
  output logic               mem_wen,
  output tcdm_pkg::be_t      mem_be,
  output tcdm_pkg::data_t    mem_data,
  input  logic               mem_gnt,
  input  logic               mem_r_valid,
  input  tcdm_pkg::data_t    mem_r_data
);

  tcdm_pkg::init_id_t user_q; // tag of the last accepted request

  // request fields straight through, user field not forwarded to the bank
  assign mem_req  = tgt_req;
  assign mem_add  = tgt_add;
  assign mem_wen  = tgt_wen;
  assign mem_be   = tgt_be;
  assign mem_data = tgt_data;

  // response fields straight through, tag from the holding register
  assign tgt_gnt     = mem_gnt;
  assign tgt_r_valid = mem_r_valid;
  assign tgt_r_data  = mem_r_data;
  assign tgt_r_user  = user_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear_i) begin
      user_q <= '0;                         // clear wins over capture
    end else if (enable_i && tgt_req && tgt_gnt) begin
      user_q <= tgt_user;                   // capture on an accepted request
    end
  end

  // the held tag is only valid if the bank answers a read in exactly one cycle
  a_read_gnt_then_r_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (mem_gnt && mem_wen) |=> mem_r_valid
  ) else $error("r_valid missing one cycle after a granted read");

  // no grant means no response in the next cycle
  a_no_gnt_then_no_r_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !mem_gnt |=> !mem_r_valid
  ) else $error("r_valid raised one cycle after a cycle without grant");

endmodule

`default_nettype wire

//--- design/tcdm_port_mux.sv
// port multiplexer module forwarding the winning request and steering responses by tag
`default_nettype none

module tcdm_port_mux (
  input  tcdm_pkg::init_id_t sel,                             // winner from the arbiter
  // initiator side requests
  input  logic               req     [tcdm_pkg::NumInit],
  input  tcdm_pkg::addr_t    add     [tcdm_pkg::NumInit],
  input  logic               wen     [tcdm_pkg::NumInit],     // high means read
  input  tcdm_pkg::be_t      be      [tcdm_pkg::NumInit],
  input  tcdm_pkg::data_t    data    [tcdm_pkg::NumInit],
  // initiator side responses
  output logic               r_valid [tcdm_pkg::NumInit],
  output tcdm_pkg::data_t    r_data  [tcdm_pkg::NumInit],
  // target side request
  output logic               tgt_req,
  output tcdm_pkg::addr_t    tgt_add,
  output logic               tgt_wen,
  output tcdm_pkg::be_t      tgt_be,
  output tcdm_pkg::data_t    tgt_data,
  output tcdm_pkg::init_id_t tgt_user,                         // tag naming the issuer
  // target side response
  input  logic               tgt_r_valid,
  input  tcdm_pkg::data_t    tgt_r_data,
  input  tcdm_pkg::init_id_t tgt_r_user                        // tag returned with the data
);

  // request direction
  assign tgt_req  = req[sel];  // winner's strobe
  assign tgt_add  = add[sel];
  assign tgt_wen  = wen[sel];
  assign tgt_be   = be[sel];
  assign tgt_data = data[sel];
  assign tgt_user = sel;       // stamp the issuer index into the user field

  // response direction
  always_comb begin
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      r_valid[i] = tgt_r_valid && (tgt_r_user == tcdm_pkg::init_id_t'(i)); // only the tagged one
      r_data[i]  = tgt_r_data;                                             // data shared by all
    end
  end

endmodule

`default_nettype wire

//--- design/tcdm_arbiter.sv
// round-robin arbiter module granting one of two initiators per cycle
`default_nettype none

module tcdm_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req [tcdm_pkg::NumInit], // per-initiator request strobes
  input  logic               tgt_gnt,                 // grant coming back from the bank side
  output logic               gnt [tcdm_pkg::NumInit], // one-hot grant to the initiators
  output tcdm_pkg::init_id_t sel                      // index of the winner
);

  tcdm_pkg::arb_state_e state_q, state_d;       // priority for the next contest
  logic [tcdm_pkg::NumInit-1:0] req_vec;        // packed copies for the checks
  logic [tcdm_pkg::NumInit-1:0] gnt_vec;
  logic accept;                                 // some request taken this cycle

  // winner selection, purely combinational
  always_comb begin
    if (req[0] && req[1]) begin
      sel = (state_q == tcdm_pkg::prio_1) ? 1'b1 : 1'b0; // contested, follow priority
    end else if (req[1]) begin
      sel = 1'b1;                                         // lone requester 1
    end else begin
      sel = 1'b0;                                         // lone requester 0 or idle
    end
  end

  // grants qualified by the target grant
  always_comb begin
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      gnt[i]     = tgt_gnt && req[i] && (sel == tcdm_pkg::init_id_t'(i));
      gnt_vec[i] = gnt[i];
      req_vec[i] = req[i];
    end
  end

  assign accept = |gnt_vec;

  // hand priority to the other initiator after every accepted request
  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d = (sel == 1'b0) ? tcdm_pkg::prio_1 : tcdm_pkg::prio_0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tcdm_pkg::prio_0; // initiator 0 first out of reset
    end else begin
      state_q <= state_d;
    end
  end

  // never two grants at once
  a_gnt_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_vec)
  ) else $error("arbiter granted more than one initiator: gnt=%b", gnt_vec);

  // a grant always lands on a requesting initiator
  a_gnt_to_requester: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (gnt_vec & ~req_vec) == '0
  ) else $error("arbiter granted an idle initiator: gnt=%b req=%b", gnt_vec, req_vec);

endmodule

`default_nettype wire

//--- design/tcdm_pkg.sv
// subsystem sizes, field widths, field typedefs and the arbiter state enum
`default_nettype none

package tcdm_pkg;

  // subsystem sizes
  localparam int unsigned NumInit   = 2;            // initiators sharing the bank
  localparam int unsigned AddrWidth = 8;            // word address bits
  localparam int unsigned NumWords  = 2**AddrWidth; // 256 words in the bank
  localparam int unsigned DataWidth = 32;           // data word bits
  localparam int unsigned BeWidth   = 4;            // one enable per byte
  localparam int unsigned ByteWidth = DataWidth / BeWidth; // bits per byte lane
  localparam int unsigned IdWidth   = 1;            // enough for NumInit initiators

  // request and response fields
  typedef logic [AddrWidth-1:0] addr_t;   // word address
  typedef logic [DataWidth-1:0] data_t;   // write or read data word
  typedef logic [BeWidth-1:0]   be_t;     // byte enables
  typedef logic [IdWidth-1:0]   init_id_t; // initiator index, also the user field

  // which initiator wins the next contested cycle
  typedef enum logic {
    prio_0, // initiator 0 favoured
    prio_1  // initiator 1 favoured
  } arb_state_e;

endpackage

`default_nettype wire
